// File: hyper_front.f
hdl/hyper_cfg_pkg.sv
hdl/hyper_xfer_pkg.sv
hdl/hyper_cfg_regs.sv
hdl/hyper_addr_decode.sv
hdl/hyper_cs_timer.sv
hdl/hyper_resp_gen.sv
hdl/hyper_front.sv
sim/hyper_front_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the HyperBus front end testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module hyper_front_tb -f hyper_front.f \
    -Mdir obj_dir -o hyper_front_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/hyper_front_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q '\*\* FAIL \*\*' "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

// File: sim/hyper_front_tb.sv
/* Testbench for the HyperBus front end. Drives register and transfer traffic
   and checks every response against a reference model with assertions. */
`timescale 1ns/1ps

module hyper_front_tb import hyper_cfg_pkg::*, hyper_xfer_pkg::*; ();

    localparam int N_BATCH     = 4;
    localparam int N_PER_BATCH = 24;
    localparam int N_XFER      = N_BATCH * N_PER_BATCH + 4;
    // Worst transfer with stalls, plus register traffic
    localparam longint WATCHDOG_NS = (N_XFER * (2 * 15 + 16 + 15 + 8) + 2000) * 10;

    // Expected chip-select event of one hit
    typedef struct packed {
        logic [CHIP_BITS-1:0] chip;
        logic [5:0]           low;
        logic [3:0]           rec;
    } cs_exp_t;

    logic                 clk_i;
    logic                 rst_n_i;
    reg_req_t             reg_req_i;
    reg_rsp_t             reg_rsp_o;
    xfer_req_t            xfer_req_i;
    logic                 xfer_req_valid_i;
    logic                 xfer_rsp_ready_i = 1'b1;
    logic                 xfer_req_ready_o;
    logic [NUM_CHIPS-1:0] cs_n_o;
    xfer_rsp_t            xfer_rsp_o;
    logic                 xfer_rsp_valid_o;

    logic [31:0]          reg_model [NUM_REGS];
    xfer_rsp_t            rsp_exp [$];
    cs_exp_t              cs_exp [$];
    integer               seed = 32'hf5fc_268c;
    int                   rsp_mode;
    int                   stretch;
    int                   acc_cnt;
    int                   done_cnt;
    int                   low_cnt;
    int                   high_cnt;
    int                   hit_chip;
    logic [3:0]           last_rec;
    logic                 seen_rise;
    logic [NUM_CHIPS-1:0] prev_cs;
    logic [NUM_CHIPS-1:0] exp_cs;
    logic [5:0]           lat_now;
    xfer_rsp_t            rsp_head;
    cs_exp_t              cs_head;

    hyper_front hyper_front_i (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .reg_req_i        (reg_req_i),
        .xfer_req_i       (xfer_req_i),
        .xfer_req_valid_i (xfer_req_valid_i),
        .xfer_rsp_ready_i (xfer_rsp_ready_i),
        .reg_rsp_o        (reg_rsp_o),
        .xfer_req_ready_o (xfer_req_ready_o),
        .cs_n_o           (cs_n_o),
        .xfer_rsp_o       (xfer_rsp_o),
        .xfer_rsp_valid_o (xfer_rsp_valid_o)
    );

    always #5 clk_i = ~clk_i;

    task automatic fail_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
        $display("** FAIL **");
        $display("FAIL at %0d ns: %s expected 0x%0h, got 0x%0h", $time, sig, exp, act);
        $fatal(1, "Value mismatch");
    endtask

    task automatic fail_text(input string what);
        $display("** FAIL **");
        $display("At %0d ns: %s", $time, what);
        $fatal(1, "Check failed");
    endtask

    // Implemented bits of each register
    function automatic logic [31:0] field_mask(input int idx);
        case (idx)
            0, 3, 4, 5: return 32'hf;
            1:          return 32'h1;
            2:          return 32'hffff;
            default:    return 32'hffff_ffff;
        endcase
    endfunction

    // First window holding addr, -1 on a miss
    function automatic int find_chip(input logic [31:0] addr);
        for (int c = 0; c < NUM_CHIPS; c++) begin
            if (addr >= reg_model[6 + 2 * c] && addr < reg_model[7 + 2 * c]) begin
                return c;
            end
        end
        return -1;
    endfunction

    task automatic reg_access(input logic [31:0] addr, input logic write,
                              input logic [31:0] data, input logic [3:0] strb);
        logic [31:0] idx;
        logic [31:0] mask;
        logic [31:0] exp_rd;
        idx    = addr >> 2;
        mask   = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        exp_rd = (idx < NUM_REGS) ? reg_model[idx] : 32'h0;
        @(negedge clk_i);
        reg_req_i = '{valid: 1'b1, write: write, addr: addr, wdata: data, wstrb: strb};
        #1;
        assert (reg_rsp_o.ready) else fail_value("reg_rsp_o.ready", 32'd1, 32'd0);
        assert (reg_rsp_o.error == (idx >= NUM_REGS))
            else fail_value("reg_rsp_o.error", 32'(idx >= NUM_REGS), 32'(reg_rsp_o.error));
        assert (write || reg_rsp_o.rdata == exp_rd)
            else fail_value("reg_rsp_o.rdata", exp_rd, reg_rsp_o.rdata);
        @(posedge clk_i);
        if (write && idx < NUM_REGS) begin
            reg_model[idx] = ((reg_model[idx] & ~mask) | (data & mask)) & field_mask(idx);
        end
        @(negedge clk_i);
        reg_req_i.valid = 1'b0;
    endtask

    task automatic check_all_regs();
        for (int i = 0; i < NUM_REGS; i++) begin
            reg_access(32'(i * 4), 1'b0, 32'h0, 4'h0);
        end
    endtask

    task automatic send_xfer(input logic [31:0] addr, input logic write, input logic [3:0] len);
        @(negedge clk_i);
        xfer_req_i       = '{addr: addr, write: write, len: len};
        xfer_req_valid_i = 1'b1;
        do begin
            @(posedge clk_i);
        end while (!xfer_req_ready_o);
    endtask

    task automatic wait_drain();
        @(negedge clk_i);
        xfer_req_valid_i = 1'b0;
        while (rsp_exp.size() != 0) begin
            @(negedge clk_i);
        end
    endtask

    task automatic run_batch(input logic [3:0] lat, input logic add, input logic [3:0] rec);
        logic [31:0] addr;
        reg_access(32'h0, 1'b1, 32'(lat), 4'hf);
        reg_access(32'h4, 1'b1, 32'(add), 4'hf);
        reg_access(32'hc, 1'b1, 32'(rec), 4'hf);
        rsp_mode = 1;
        @(posedge clk_i);
        for (int n = 0; n < N_PER_BATCH; n++) begin
            // Spans both windows and misses on either side
            addr = 32'h1f80_0000 + ($unsigned($random(seed)) % 32'h0300_0000);
            send_xfer(addr, 1'($random(seed)), 4'($random(seed)));
        end
        wait_drain();
        rsp_mode = 0;
    endtask

    // Response back-pressure, random stretches of 1 to 8 cycles
    always @(negedge clk_i) begin
        if (rsp_mode == 1) begin
            if (stretch == 0) begin
                xfer_rsp_ready_i = 1'($random(seed));
                stretch          = $unsigned($random(seed)) % 8;
            end else begin
                stretch = stretch - 1;
            end
        end else begin
            xfer_rsp_ready_i = (rsp_mode == 0);
        end
    end

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            prev_cs   = '1;
            low_cnt   = 0;
            high_cnt  = 0;
            seen_rise = 1'b0;
        end else begin
            if (xfer_req_valid_i && xfer_req_ready_o) begin
                hit_chip       = find_chip(xfer_req_i.addr);
                rsp_head.chip  = CHIP_BITS'(hit_chip < 0 ? 0 : hit_chip);
                rsp_head.write = xfer_req_i.write;
                rsp_head.error = hit_chip < 0;
                rsp_exp.push_back(rsp_head);
                if (hit_chip >= 0) begin
                    lat_now = reg_model[1][0] ? 6'(2 * reg_model[0][3:0])
                                              : 6'(reg_model[0][3:0]);
                    cs_head.chip = rsp_head.chip;
                    cs_head.low  = 6'(lat_now + xfer_req_i.len + 1);
                    cs_head.rec  = reg_model[3][3:0];
                    cs_exp.push_back(cs_head);
                end
                acc_cnt++;
            end
            if (xfer_rsp_valid_o && xfer_rsp_ready_i) begin
                assert (rsp_exp.size() != 0) else fail_text("response with no request pending");
                rsp_head = rsp_exp.pop_front();
                assert (xfer_rsp_o.error == rsp_head.error)
                    else fail_value("xfer_rsp_o.error", 32'(rsp_head.error), 32'(xfer_rsp_o.error));
                assert (xfer_rsp_o.write == rsp_head.write)
                    else fail_value("xfer_rsp_o.write", 32'(rsp_head.write), 32'(xfer_rsp_o.write));
                assert (rsp_head.error || xfer_rsp_o.chip == rsp_head.chip)
                    else fail_value("xfer_rsp_o.chip", 32'(rsp_head.chip), 32'(xfer_rsp_o.chip));
                done_cnt++;
            end
            if (cs_n_o != '1 && prev_cs == '1) begin
                assert (cs_exp.size() != 0) else fail_text("chip select fell with no hit pending");
                exp_cs = ~(NUM_CHIPS'(1) << cs_exp[0].chip);
                assert (cs_n_o == exp_cs) else fail_value("cs_n_o", 32'(exp_cs), 32'(cs_n_o));
                assert (!seen_rise || high_cnt >= last_rec)
                    else fail_value("cs_n_o recovery cycles", 32'(last_rec), 32'(high_cnt));
                low_cnt = 1;
            end else if (cs_n_o != '1) begin
                assert (cs_n_o == prev_cs) else fail_value("cs_n_o", 32'(prev_cs), 32'(cs_n_o));
                low_cnt++;
            end else if (prev_cs != '1) begin
                cs_head = cs_exp.pop_front();
                assert (low_cnt == cs_head.low)
                    else fail_value("cs_n_o low cycles", 32'(cs_head.low), 32'(low_cnt));
                last_rec  = cs_head.rec;
                seen_rise = 1'b1;
                high_cnt  = 1;
            end else begin
                high_cnt++;
            end
            prev_cs = cs_n_o;
        end
    end

    a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        xfer_rsp_valid_o && !xfer_rsp_ready_i |=> xfer_rsp_valid_o && $stable(xfer_rsp_o))
        else fail_text("xfer_rsp_o changed while the response was stalled");

    initial begin
        #(WATCHDOG_NS);
        $display("** FAIL **");
        $display("Timeout after %0d ns, the transfers did not complete", WATCHDOG_NS);
        $fatal(1, "Timeout");
    end

    initial begin
        clk_i            = 1'b0;
        rst_n_i          = 1'b0;
        reg_req_i        = '0;
        xfer_req_i       = '0;
        xfer_req_valid_i = 1'b0;
        rsp_mode         = 0;
        stretch          = 0;
        acc_cnt          = 0;
        done_cnt         = 0;
        reg_model[0]     = 32'd6;
        reg_model[1]     = 32'd1;
        reg_model[2]     = 32'd665;
        reg_model[3]     = 32'd6;
        reg_model[4]     = 32'd2;
        reg_model[5]     = 32'd3;
        for (int c = 0; c < NUM_CHIPS; c++) begin
            reg_model[6 + 2 * c] = 32'h0040_0000 * c;
            reg_model[7 + 2 * c] = 32'h0040_0000 * (c + 1);
        end
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        #1;
        assert (cs_n_o == '1) else fail_value("cs_n_o", 32'h3, 32'(cs_n_o));
        assert (!xfer_rsp_valid_o) else fail_value("xfer_rsp_valid_o", 32'd0, 32'd1);
        assert (xfer_req_ready_o) else fail_value("xfer_req_ready_o", 32'd1, 32'd0);
        check_all_regs();

        // Byte strobes, then accesses past the map
        reg_access(32'h18, 1'b1, 32'ha5a5_5a5a, 4'b0101);
        reg_access(32'h08, 1'b1, 32'hdead_beef, 4'b0010);
        reg_access(32'h18, 1'b0, 32'h0, 4'h0);
        reg_access(32'h08, 1'b0, 32'h0, 4'h0);
        reg_access(32'h28, 1'b1, 32'hffff_ffff, 4'hf);
        reg_access(32'h28, 1'b0, 32'h0, 4'h0);
        reg_access(32'h400, 1'b1, 32'h1234_5678, 4'hf);
        check_all_regs();

        // Overlapping windows, chip 0 wins the overlap
        reg_access(32'h18, 1'b1, 32'h2000_0000, 4'hf);
        reg_access(32'h1c, 1'b1, 32'h2100_0000, 4'hf);
        reg_access(32'h20, 1'b1, 32'h2080_0000, 4'hf);
        reg_access(32'h24, 1'b1, 32'h2200_0000, 4'hf);
        run_batch(4'd6, 1'b1, 4'd6);
        run_batch(4'd3, 1'b0, 4'd0);
        run_batch(4'd15, 1'b1, 4'd15);
        run_batch(4'd0, 1'b0, 4'd2);

        // Fill decode, execute and result, the fourth must wait
        rsp_mode = 2;
        for (int n = 0; n < 3; n++) begin
            send_xfer(32'h2000_0100 + 32'(n), 1'b0, 4'd3);
        end
        @(negedge clk_i);
        xfer_req_i = '{addr: 32'h2180_0000, write: 1'b1, len: 4'd1};
        for (int n = 0; n < 64; n++) begin
            @(posedge clk_i);
            assert (!xfer_req_ready_o) else fail_value("xfer_req_ready_o", 32'd0, 32'd1);
        end
        assert (acc_cnt == N_BATCH * N_PER_BATCH + 3)
            else fail_value("accepted requests", 32'(N_BATCH * N_PER_BATCH + 3), 32'(acc_cnt));
        rsp_mode = 0;
        do begin
            @(posedge clk_i);
        end while (!xfer_req_ready_o);
        wait_drain();

        assert (acc_cnt == N_XFER) else fail_value("accepted requests", 32'(N_XFER), 32'(acc_cnt));
        assert (done_cnt == N_XFER) else fail_value("responses", 32'(N_XFER), 32'(done_cnt));
        assert (cs_exp.size() == 0) else fail_text("a hit never drove its chip select");
        $display("** PASS **");
        $finish;
    end

endmodule

// File: hdl/hyper_front.sv
/* HyperBus control front end, joins the register file with the decode, execute
   and result stages of the transfer path. */
`timescale 1ns/1ps

module hyper_front import hyper_cfg_pkg::*, hyper_xfer_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  reg_req_t             reg_req_i,
    input  xfer_req_t            xfer_req_i,
    input  logic                 xfer_req_valid_i,
    input  logic                 xfer_rsp_ready_i,
    output reg_rsp_t             reg_rsp_o,
    output logic                 xfer_req_ready_o,
    output logic [NUM_CHIPS-1:0] cs_n_o,
    output xfer_rsp_t            xfer_rsp_o,
    output logic                 xfer_rsp_valid_o
);

    hyper_cfg_t                 cfg;
    chip_rule_t [NUM_CHIPS-1:0] chip_rules;
    xfer_cmd_t                  cmd;
    logic                       cmd_valid;
    logic                       cmd_ready;
    xfer_cmd_t                  done;
    logic                       done_valid;
    logic                       done_ready;

    hyper_cfg_regs cfg_regs_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .reg_req_i    (reg_req_i),
        .reg_rsp_o    (reg_rsp_o),
        .cfg_o        (cfg),
        .chip_rules_o (chip_rules)
    );

    hyper_addr_decode addr_decode_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (xfer_req_i),
        .req_valid_i  (xfer_req_valid_i),
        .chip_rules_i (chip_rules),
        .cmd_ready_i  (cmd_ready),
        .req_ready_o  (xfer_req_ready_o),
        .cmd_o        (cmd),
        .cmd_valid_o  (cmd_valid)
    );

    hyper_cs_timer cs_timer_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cfg_i       (cfg),
        .cmd_i       (cmd),
        .cmd_valid_i (cmd_valid),
        .rsp_ready_i (done_ready),
        .cmd_ready_o (cmd_ready),
        .cs_n_o      (cs_n_o),
        .rsp_o       (done),
        .rsp_valid_o (done_valid)
    );

    hyper_resp_gen resp_gen_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rsp_i       (done),
        .rsp_valid_i (done_valid),
        .rsp_ready_i (xfer_rsp_ready_i),
        .rsp_ready_o (done_ready),
        .rsp_o       (xfer_rsp_o),
        .rsp_valid_o (xfer_rsp_valid_o)
    );

endmodule

// File: hdl/hyper_resp_gen.sv
/* Result stage, a one-entry buffer that turns each finished command into a response. */
`timescale 1ns/1ps

module hyper_resp_gen import hyper_xfer_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  xfer_cmd_t rsp_i,
    input  logic      rsp_valid_i,
    input  logic      rsp_ready_i,
    output logic      rsp_ready_o,
    output xfer_rsp_t rsp_o,
    output logic      rsp_valid_o
);

    logic load;

    assign rsp_ready_o = !rsp_valid_o || rsp_ready_i;
    assign load        = rsp_valid_i && rsp_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
        end else if (load) begin
            rsp_valid_o <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_o <= 1'b0;
        end
    end

    // Unmapped address reports as error
    always_ff @(posedge clk_i) begin
        if (load) begin
            rsp_o.chip  <= rsp_i.chip;
            rsp_o.write <= rsp_i.req.write;
            rsp_o.error <= ~rsp_i.hit;
        end
    end

    a_rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o));

endmodule

// File: hdl/hyper_cs_timer.sv
/* Execute stage, times the latency, data and recovery phases of each command.
   Drives the registered chip selects and hands the finished command to the result stage. */
`timescale 1ns/1ps

module hyper_cs_timer import hyper_cfg_pkg::*, hyper_xfer_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  hyper_cfg_t           cfg_i,
    input  xfer_cmd_t            cmd_i,
    input  logic                 cmd_valid_i,
    input  logic                 rsp_ready_i,
    output logic                 cmd_ready_o,
    output logic [NUM_CHIPS-1:0] cs_n_o,
    output xfer_cmd_t            rsp_o,
    output logic                 rsp_valid_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_HOLD,
        ST_RECOVER
    } state_e;

    state_e              state_q;
    logic [LAT_BITS-1:0] cnt_q;
    logic [3:0]          rec_q;
    xfer_cmd_t           cmd_q;
    logic [LAT_BITS-1:0] lat;
    logic                accept;

    // Additional latency doubles the access latency
    assign lat = cfg_i.en_latency_additional ? {cfg_i.t_latency_access, 1'b0}
                                             : {1'b0, cfg_i.t_latency_access};

    // A new command needs both the FSM and the response slot free
    assign cmd_ready_o = (state_q == ST_IDLE) && (!rsp_valid_o || rsp_ready_i);
    assign accept      = cmd_valid_i && cmd_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= ST_IDLE;
            cnt_q       <= '0;
            cs_n_o      <= '1;
            rsp_valid_o <= 1'b0;
        end else begin
            if (rsp_valid_o && rsp_ready_i) begin
                rsp_valid_o <= 1'b0;
            end
            case (state_q)
                ST_IDLE: begin
                    if (accept && !cmd_i.hit) begin
                        rsp_valid_o <= 1'b1;
                    end else if (accept) begin
                        cs_n_o <= ~(NUM_CHIPS'(1) << cmd_i.chip);
                        if (lat == '0) begin
                            state_q <= ST_HOLD;
                            cnt_q   <= LAT_BITS'(cmd_i.req.len);
                        end else begin
                            state_q <= ST_ACCESS;
                            cnt_q   <= lat - 1'b1;
                        end
                    end
                end
                ST_ACCESS: begin
                    if (cnt_q == '0) begin
                        state_q <= ST_HOLD;
                        cnt_q   <= LAT_BITS'(cmd_q.req.len);
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                ST_HOLD: begin
                    if (cnt_q == '0) begin
                        cs_n_o      <= '1;
                        rsp_valid_o <= 1'b1;
                        if (rec_q == '0) begin
                            state_q <= ST_IDLE;
                        end else begin
                            state_q <= ST_RECOVER;
                            cnt_q   <= LAT_BITS'(rec_q - 4'd1);
                        end
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                default: begin
                    // Recovery gap overlaps the pending response
                    if (cnt_q == '0) begin
                        state_q <= ST_IDLE;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            cmd_q <= cmd_i;
            rec_q <= cfg_i.t_read_write_recovery;
        end
    end

    assign rsp_o = cmd_q;

    a_cs_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(~cs_n_o));

endmodule

// File: hdl/hyper_addr_decode.sv
/* Decode stage, maps a request address to a chip through the window rules.
   One-entry output register, refilled in the cycle its command is taken. */
`timescale 1ns/1ps

module hyper_addr_decode import hyper_cfg_pkg::*, hyper_xfer_pkg::*; (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  xfer_req_t                  req_i,
    input  logic                       req_valid_i,
    input  chip_rule_t [NUM_CHIPS-1:0] chip_rules_i,
    input  logic                       cmd_ready_i,
    output logic                       req_ready_o,
    output xfer_cmd_t                  cmd_o,
    output logic                       cmd_valid_o
);

    xfer_cmd_t dec;

    // First matching window wins
    always_comb begin
        dec.chip = '0;
        dec.hit  = 1'b0;
        dec.req  = req_i;
        for (int i = 0; i < NUM_CHIPS; i++) begin
            if (!dec.hit && req_i.addr >= chip_rules_i[i].start_addr &&
                    req_i.addr < chip_rules_i[i].end_addr) begin
                dec.hit  = 1'b1;
                dec.chip = chip_rules_i[i].idx;
            end
        end
    end

    assign req_ready_o = !cmd_valid_o || cmd_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cmd_valid_o <= 1'b0;
        end else if (req_valid_i && req_ready_o) begin
            cmd_valid_o <= 1'b1;
        end else if (cmd_ready_i) begin
            cmd_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            cmd_o <= dec;
        end
    end

    a_cmd_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cmd_valid_o && !cmd_ready_i |=> cmd_valid_o && $stable(cmd_o));

endmodule

// File: hdl/hyper_cfg_regs.sv
/* Timing and chip window registers behind the 32-bit register bus.
   Reads are combinational, writes land at the next clock edge under the byte strobes. */
`timescale 1ns/1ps

module hyper_cfg_regs import hyper_cfg_pkg::*; (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  reg_req_t                     reg_req_i,
    output reg_rsp_t                     reg_rsp_o,
    output hyper_cfg_t                   cfg_o,
    output chip_rule_t [NUM_CHIPS-1:0]   chip_rules_o
);

    hyper_cfg_t                      cfg_q;
    // Per chip, word 0 is the start and word 1 the exclusive end
    logic [NUM_CHIPS-1:0][1:0][31:0] win_q;

    logic [29:0]         reg_idx;
    logic [REG_BITS-1:0] sel;
    logic [REG_BITS-1:0] chip_off;
    logic                mapped;
    logic                wr_en;
    logic [31:0]         wmask;
    logic [31:0]         cur;
    logic [31:0]         wnew;

    assign reg_idx  = reg_req_i.addr[31:2];
    assign mapped   = reg_idx < 30'(NUM_REGS);
    assign sel      = reg_idx[REG_BITS-1:0];
    assign chip_off = sel - REG_CHIP_BASE;
    assign wr_en    = reg_req_i.valid & reg_req_i.write & mapped;

    assign wmask = {{8{reg_req_i.wstrb[3]}}, {8{reg_req_i.wstrb[2]}},
                    {8{reg_req_i.wstrb[1]}}, {8{reg_req_i.wstrb[0]}}};

    // Current word of the selected register
    always_comb begin
        case (sel)
            REG_LATENCY:     cur = 32'(cfg_q.t_latency_access);
            REG_ADD_LATENCY: cur = 32'(cfg_q.en_latency_additional);
            REG_CS_MAX:      cur = 32'(cfg_q.t_cs_max);
            REG_RECOVERY:    cur = 32'(cfg_q.t_read_write_recovery);
            REG_DELAY_LINE:  cur = 32'(cfg_q.t_rwds_delay_line);
            REG_VAR_LATENCY: cur = 32'(cfg_q.t_variable_latency_check);
            default:         cur = win_q[chip_off[CHIP_BITS:1]][chip_off[0]];
        endcase
    end

    assign wnew = (cur & ~wmask) | (reg_req_i.wdata & wmask);

    assign reg_rsp_o.rdata = mapped ? cur : 32'h0;
    assign reg_rsp_o.ready = 1'b1;
    assign reg_rsp_o.error = reg_req_i.valid & ~mapped;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cfg_q <= CFG_RST;
            for (int i = 0; i < NUM_CHIPS; i++) begin
                win_q[i][0] <= WIN_SIZE * i;
                win_q[i][1] <= WIN_SIZE * (i + 1);
            end
        end else if (wr_en) begin
            case (sel)
                REG_LATENCY:     cfg_q.t_latency_access         <= wnew[3:0];
                REG_ADD_LATENCY: cfg_q.en_latency_additional    <= wnew[0];
                REG_CS_MAX:      cfg_q.t_cs_max                 <= wnew[15:0];
                REG_RECOVERY:    cfg_q.t_read_write_recovery    <= wnew[3:0];
                REG_DELAY_LINE:  cfg_q.t_rwds_delay_line        <= wnew[3:0];
                REG_VAR_LATENCY: cfg_q.t_variable_latency_check <= wnew[3:0];
                default:         win_q[chip_off[CHIP_BITS:1]][chip_off[0]] <= wnew;
            endcase
        end
    end

    assign cfg_o = cfg_q;

    for (genvar i = 0; i < NUM_CHIPS; i++) begin : gen_rules
        assign chip_rules_o[i].idx        = CHIP_BITS'(i);
        assign chip_rules_o[i].start_addr = win_q[i][0];
        assign chip_rules_o[i].end_addr   = win_q[i][1];
    end

    // A rejected write must leave every register untouched
    a_err_no_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        reg_rsp_o.error && reg_req_i.write |=> $stable(cfg_q) && $stable(win_q));

endmodule

// File: hdl/hyper_xfer_pkg.sv
/* Types carried along the transfer path from request through decode, execute and result. */
package hyper_xfer_pkg;

    import hyper_cfg_pkg::*;

    // Data phase lasts len+1 cycles
    typedef struct packed {
        logic [31:0] addr;
        logic        write;
        logic [3:0]  len;
    } xfer_req_t;

    // Request after address decode
    typedef struct packed {
        logic [CHIP_BITS-1:0] chip;
        logic                 hit;
        xfer_req_t            req;
    } xfer_cmd_t;

    typedef struct packed {
        logic [CHIP_BITS-1:0] chip;
        logic                 write;
        logic                 error;
    } xfer_rsp_t;

endpackage

// File: hdl/hyper_cfg_pkg.sv
/* Register map, reset values and configuration types of the HyperBus front end.
   Imported by the register file, the address decoder and the chip-select timer. */
package hyper_cfg_pkg;

    localparam int unsigned NUM_CHIPS = 2;
    localparam int unsigned NUM_REGS  = 6 + 2 * NUM_CHIPS;
    localparam int unsigned REG_BITS  = $clog2(NUM_REGS);
    localparam int unsigned CHIP_BITS = 1;

    // Latency counter width, doubled 4-bit latency fits
    localparam int unsigned LAT_BITS = 5;

    // Register indices, counted in 32-bit words
    localparam logic [REG_BITS-1:0] REG_LATENCY     = 'd0;
    localparam logic [REG_BITS-1:0] REG_ADD_LATENCY = 'd1;
    localparam logic [REG_BITS-1:0] REG_CS_MAX      = 'd2;
    localparam logic [REG_BITS-1:0] REG_RECOVERY    = 'd3;
    localparam logic [REG_BITS-1:0] REG_DELAY_LINE  = 'd4;
    localparam logic [REG_BITS-1:0] REG_VAR_LATENCY = 'd5;
    localparam logic [REG_BITS-1:0] REG_CHIP_BASE   = 'd6;

    // Default size of one chip window
    localparam logic [31:0] WIN_SIZE = 32'h0040_0000;

    typedef struct packed {
        logic        valid;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } reg_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        ready;
        logic        error;
    } reg_rsp_t;

    typedef struct packed {
        logic [3:0]  t_latency_access;
        logic        en_latency_additional;
        logic [15:0] t_cs_max;
        logic [3:0]  t_read_write_recovery;
        logic [3:0]  t_rwds_delay_line;
        logic [3:0]  t_variable_latency_check;
    } hyper_cfg_t;

    typedef struct packed {
        logic [CHIP_BITS-1:0] idx;
        logic [31:0]          start_addr;
        logic [31:0]          end_addr;
    } chip_rule_t;

    localparam hyper_cfg_t CFG_RST = '{
        t_latency_access:         4'd6,
        en_latency_additional:    1'b1,
        t_cs_max:                 16'd665,
        t_read_write_recovery:    4'd6,
        t_rwds_delay_line:        4'd2,
        t_variable_latency_check: 4'd3
    };

endpackage
